// File: source/av_consts.svh
////////////////////////////////////////////////////////////
// raster geometry, i2s framing and register map constants
// for the audio/video signal generator
////////////////////////////////////////////////////////////

`ifndef AV_CONSTS_SVH
`define AV_CONSTS_SVH

////////////////////////////////////////////////////////////
// raster geometry
////////////////////////////////////////////////////////////

// pixels per line
`define AV_H_BPORCH     10
`define AV_H_ACTIVE     260
`define AV_H_TOTAL      280

// lines per frame
`define AV_V_BPORCH     10
`define AV_V_ACTIVE     234
`define AV_V_TOTAL      850

// hsync column, a few pixels after vsync
`define AV_HS_X         3

////////////////////////////////////////////////////////////
// i2s framing
////////////////////////////////////////////////////////////

// master clocks per bit clock
`define AV_SCLK_DIV     4
// bit clocks per channel slot
`define AV_SLOT_BITS    32
// active sample bits at the head of each slot
`define AV_SAMPLE_BITS  16

////////////////////////////////////////////////////////////
// register map
////////////////////////////////////////////////////////////

// top address byte of the register window
`define AV_REG_REGION   8'hF8

// byte offsets inside the window, low 24 address bits
`define AV_REG_COLOR    24'h00_0000
`define AV_REG_LEFT     24'h00_0004
`define AV_REG_RIGHT    24'h00_0008
`define AV_REG_FRAMES   24'h00_000C

`endif

// File: source/av_pkg.sv
////////////////////////////////////////////////////////////
// shared struct types: wishbone request and response,
// control registers, video and i2s output bundles
////////////////////////////////////////////////////////////

`default_nettype none

package av_pkg;

    ////////////////////////////////////////////////////////////
    // wishbone classic
    ////////////////////////////////////////////////////////////

    // master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    // slave to master, dat valid with ack
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    ////////////////////////////////////////////////////////////
    // control registers
    ////////////////////////////////////////////////////////////

    // 4 bits per channel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb444_t;

    // everything the generators need from the bus side
    typedef struct packed {
        rgb444_t     color;
        logic [15:0] left;
        logic [15:0] right;
    } av_ctrl_t;

    ////////////////////////////////////////////////////////////
    // generator outputs
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [23:0] rgb;
        logic        de;
        logic        vs;
        logic        hs;
    } video_out_t;

    typedef struct packed {
        logic sclk;
        logic lrck;
        logic dac;
    } i2s_out_t;

endpackage

`default_nettype wire

// File: source/av_bus_regs.sv
////////////////////////////////////////////////////////////
// wishbone classic slave, fixed one cycle to ack
// colour, left/right sample and frame count registers
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "av_consts.svh"

module av_bus_regs (
    input  logic              audgen_mclk,
    input  logic              reset_n,
    input  av_pkg::wb_req_t   wb_req,
    output av_pkg::wb_rsp_t   wb_rsp,
    input  logic [15:0]       frame_count,
    output av_pkg::av_ctrl_t  ctrl
);

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    av_pkg::wb_rsp_t  rsp_q;
    av_pkg::av_ctrl_t ctrl_q;
    logic             req_go;
    logic             hit_region;
    logic [23:0]      offset;
    logic [31:0]      rd_mux;

    // new request seen, not already acking it
    assign req_go     = wb_req.cyc && wb_req.stb && !rsp_q.ack;
    assign hit_region = (wb_req.adr[31:24] == `AV_REG_REGION);
    assign offset     = wb_req.adr[23:0];

    // read mux, zero extended
    always_comb begin
        rd_mux = '0;
        if (hit_region) begin
            case (offset)
                `AV_REG_COLOR:  rd_mux = {20'h0, ctrl_q.color};
                `AV_REG_LEFT:   rd_mux = {16'h0, ctrl_q.left};
                `AV_REG_RIGHT:  rd_mux = {16'h0, ctrl_q.right};
                `AV_REG_FRAMES: rd_mux = {16'h0, frame_count};
                // unmapped offsets inside the window
                default:        rd_mux = '0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // handshake and registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            rsp_q  <= '0;
            ctrl_q <= '0;
        end else begin
            // single cycle ack pulse
            rsp_q.ack <= req_go;

            if (req_go) begin
                // read data lands together with ack
                rsp_q.dat <= rd_mux;

                if (wb_req.we && hit_region) begin
                    case (offset)
                        `AV_REG_COLOR: begin
                            ctrl_q.color <= av_pkg::rgb444_t'(wb_req.dat[11:0]);
                        end
                        `AV_REG_LEFT: begin
                            ctrl_q.left <= wb_req.dat[15:0];
                        end
                        `AV_REG_RIGHT: begin
                            ctrl_q.right <= wb_req.dat[15:0];
                        end
                        // frame count is read only, rest unmapped
                        default: begin
                        end
                    endcase
                end
            end
        end
    end

    assign wb_rsp = rsp_q;
    assign ctrl   = ctrl_q;

endmodule

`default_nettype wire

// File: source/video_timing_gen.sv
////////////////////////////////////////////////////////////
// raster counters, vs/hs/de generation, pixel colouring
// and frame counter
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "av_consts.svh"

module video_timing_gen (
    input  logic                audgen_mclk,
    input  logic                reset_n,
    input  av_pkg::av_ctrl_t    ctrl,
    output av_pkg::video_out_t  video,
    output logic [15:0]         frame_count
);

    // counter limits
    localparam logic [9:0] H_LAST = 10'(`AV_H_TOTAL - 1);
    localparam logic [9:0] V_LAST = 10'(`AV_V_TOTAL - 1);
    localparam logic [9:0] HS_X   = 10'(`AV_HS_X);

    // active window, low bound inclusive, high bound exclusive
    localparam logic [9:0] H_DE_LO = 10'(`AV_H_BPORCH);
    localparam logic [9:0] H_DE_HI = 10'(`AV_H_BPORCH + `AV_H_ACTIVE);
    localparam logic [9:0] V_DE_LO = 10'(`AV_V_BPORCH);
    localparam logic [9:0] V_DE_HI = 10'(`AV_V_BPORCH + `AV_V_ACTIVE);

    logic [9:0]         x_q;
    logic [9:0]         y_q;
    logic               x_active;
    logic               y_active;
    logic               frame_start;
    logic [15:0]        frame_q;
    av_pkg::video_out_t video_q;

    assign x_active    = (x_q >= H_DE_LO) && (x_q < H_DE_HI);
    assign y_active    = (y_q >= V_DE_LO) && (y_q < V_DE_HI);
    assign frame_start = (x_q == '0) && (y_q == '0);

    ////////////////////////////////////////////////////////////
    // raster counters
    ////////////////////////////////////////////////////////////

    // x runs every clock, y steps at end of line
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_q <= '0;
            y_q <= '0;
        end else if (x_q == H_LAST) begin
            x_q <= '0;
            if (y_q == V_LAST) begin
                y_q <= '0;
            end else begin
                y_q <= y_q + 10'd1;
            end
        end else begin
            x_q <= x_q + 10'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // sync, data enable and pixels
    ////////////////////////////////////////////////////////////

    // outputs trail the counters by one cycle
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video_q <= '0;
            frame_q <= '0;
        end else begin
            video_q.vs <= frame_start;
            video_q.hs <= (x_q == HS_X);
            video_q.de <= x_active && y_active;

            // nibble in the top of each channel, black when blanked
            if (x_active && y_active) begin
                video_q.rgb <= {ctrl.color.r, 4'h0,
                                ctrl.color.g, 4'h0,
                                ctrl.color.b, 4'h0};
            end else begin
                video_q.rgb <= '0;
            end

            // one count per vsync
            if (frame_start) begin
                frame_q <= frame_q + 16'd1;
            end
        end
    end

    assign video       = video_q;
    assign frame_count = frame_q;

endmodule

`default_nettype wire

// File: source/i2s_serializer.sv
////////////////////////////////////////////////////////////
// i2s output: bit clock divider, slot counter with word
// select, sample latch and msb-first shifter
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "av_consts.svh"

module i2s_serializer (
    input  logic              audgen_mclk,
    input  logic              reset_n,
    input  av_pkg::av_ctrl_t  ctrl,
    output av_pkg::i2s_out_t  i2s
);

    localparam int DIV_W  = $clog2(`AV_SCLK_DIV);
    localparam int SLOT_W = $clog2(`AV_SLOT_BITS);
    localparam int SMP_W  = `AV_SAMPLE_BITS;

    localparam logic [DIV_W-1:0]  DIV_LAST  = DIV_W'(`AV_SCLK_DIV - 1);
    localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(`AV_SLOT_BITS - 1);

    logic [DIV_W-1:0]  div_q;
    logic [SLOT_W-1:0] bit_cnt_q;
    logic              sclk_fall;
    logic              slot_end;
    logic              lrck_q;
    logic              dac_q;
    logic [SMP_W-1:0]  hold_right_q;
    logic [SMP_W-1:0]  shift_q;
    logic [SMP_W-1:0]  next_word;

    ////////////////////////////////////////////////////////////
    // bit clock
    ////////////////////////////////////////////////////////////

    // sclk is the divider msb, it falls as the divider wraps
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            div_q <= '0;
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    assign sclk_fall = (div_q == DIV_LAST);
    assign slot_end  = (bit_cnt_q == SLOT_LAST);

    // lrck high now means the left slot starts next
    // left goes straight into the shifter, right waits in hold
    assign next_word = lrck_q ? ctrl.left : hold_right_q;

    ////////////////////////////////////////////////////////////
    // slot counter and shifter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            bit_cnt_q    <= '0;
            lrck_q       <= 1'b0;
            dac_q        <= 1'b0;
            hold_right_q <= '0;
            shift_q      <= '0;
        end else if (sclk_fall) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (slot_end) begin
                // channel switch, msb out right away
                lrck_q  <= ~lrck_q;
                dac_q   <= next_word[SMP_W-1];
                shift_q <= {next_word[SMP_W-2:0], 1'b0};
                if (lrck_q) begin
                    hold_right_q <= ctrl.right;
                end
            end else begin
                // zeros shifted in fill the tail of the slot
                dac_q   <= shift_q[SMP_W-1];
                shift_q <= {shift_q[SMP_W-2:0], 1'b0};
            end
        end
    end

    assign i2s.sclk = div_q[DIV_W-1];
    assign i2s.lrck = lrck_q;
    assign i2s.dac  = dac_q;

endmodule

`default_nettype wire

// File: source/av_signal_top.sv
////////////////////////////////////////////////////////////
// signal generator top: bus registers feeding the video
// timing generator and the i2s serializer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module av_signal_top (
    input  logic                audgen_mclk,
    input  logic                reset_n,
    input  av_pkg::wb_req_t     wb_req,
    output av_pkg::wb_rsp_t     wb_rsp,
    output av_pkg::video_out_t  video,
    output av_pkg::i2s_out_t    i2s
);

    // register values out to both generators
    av_pkg::av_ctrl_t ctrl;
    // frame count back from video for readout
    logic [15:0]      frame_count;

    ////////////////////////////////////////////////////////////
    // host bus
    ////////////////////////////////////////////////////////////

    av_bus_regs u_bus_regs (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .frame_count (frame_count),
        .ctrl        (ctrl)
    );

    ////////////////////////////////////////////////////////////
    // video
    ////////////////////////////////////////////////////////////

    video_timing_gen u_video (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .ctrl        (ctrl),
        .video       (video),
        .frame_count (frame_count)
    );

    ////////////////////////////////////////////////////////////
    // audio
    ////////////////////////////////////////////////////////////

    // same clock, sclk derived inside
    i2s_serializer u_i2s (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .ctrl        (ctrl),
        .i2s         (i2s)
    );

endmodule

`default_nettype wire

// File: verif/av_signal_assert.sv
////////////////////////////////////////////////////////////
// concurrent assertions bound to the signal generator top:
// wishbone ack handshake and sync pulse exclusion
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module av_signal_assert (
    input logic               audgen_mclk,
    input logic               reset_n,
    input av_pkg::wb_req_t    wb_req,
    input av_pkg::wb_rsp_t    wb_rsp,
    input av_pkg::video_out_t video
);

    // ack is a single cycle pulse
    ack_single_cycle: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        wb_rsp.ack |=> !wb_rsp.ack
    ) else $error("ack high on two consecutive cycles");

    // fixed one cycle wait, no back-pressure
    ack_after_request: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        (wb_req.cyc && wb_req.stb && !wb_rsp.ack) |=> wb_rsp.ack
    ) else $error("no ack one cycle after a request");

    // vs at column 0, hs at column 3
    sync_exclusive: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        !(video.vs && video.hs)
    ) else $error("vs and hs high in the same cycle");

endmodule

`default_nettype wire

// File: verif/av_signal_tb.sv
////////////////////////////////////////////////////////////
// testbench for the signal generator: clock and reset,
// random wishbone traffic against a register model, raster
// and i2s checks, bound assertions and a watchdog
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "av_consts.svh"

module av_signal_tb;

    localparam int FRAME_CYCLES    = `AV_H_TOTAL * `AV_V_TOTAL;
    // three frames plus bus traffic, doubled
    localparam int WATCHDOG_CYCLES = 2 * (3 * FRAME_CYCLES + 4000);
    localparam int ACK_LIMIT       = 8;

    logic               audgen_mclk = 1'b0;
    logic               reset_n;
    av_pkg::wb_req_t    wb_req;
    av_pkg::wb_rsp_t    wb_rsp;
    av_pkg::video_out_t video;
    av_pkg::i2s_out_t   i2s;

    // register model
    av_pkg::rgb444_t    model_color = '0;
    logic [15:0]        model_left  = '0;
    logic [15:0]        model_right = '0;
    int                 vs_count    = 0;
    int                 seed;

    av_signal_top uut (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .video       (video),
        .i2s         (i2s)
    );

    bind av_signal_top av_signal_assert u_assert (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .video       (video)
    );

    // 20 ns master clock
    always #10 audgen_mclk = ~audgen_mclk;

    // frame count follows vs pulses, pre-edge values
    always @(posedge audgen_mclk) begin
        if (reset_n && video.vs) begin
            vs_count <= vs_count + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // compare and report
    ////////////////////////////////////////////////////////////

    task automatic stop_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_rsp(input string name, input av_pkg::wb_rsp_t want,
                             input av_pkg::wb_rsp_t got);
        if (got !== want) begin
            stop_run($sformatf("[FAIL] %s expected %h actual %h", name, want, got));
        end
    endtask

    task automatic check_video(input string name, input av_pkg::video_out_t want,
                               input av_pkg::video_out_t got);
        if (got !== want) begin
            stop_run($sformatf("[FAIL] %s expected %h actual %h", name, want, got));
        end
    endtask

    task automatic check_i2s_sample(input string name, input logic [15:0] want,
                                    input logic [15:0] got);
        if (got !== want) begin
            stop_run($sformatf("[FAIL] %s expected %h actual %h", name, want, got));
        end
    endtask

    task automatic expect_count(input string name, input int want, input int got);
        if (got != want) begin
            stop_run($sformatf("[FAIL] %s expected %0d actual %0d", name, want, got));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // bus master and register model
    ////////////////////////////////////////////////////////////

    // called on a falling edge, returns on the falling edge that shows ack
    task automatic bus_access(input logic we, input logic [31:0] adr,
                              input logic [31:0] dat, output av_pkg::wb_rsp_t rsp,
                              output int lat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        lat = 0;
        @(negedge audgen_mclk);
        lat++;
        while (!wb_rsp.ack) begin
            if (lat >= ACK_LIMIT) begin
                stop_run("bus slave never acknowledged the request");
            end
            @(negedge audgen_mclk);
            lat++;
        end
        rsp = wb_rsp;
        // stb low before the next rising edge
        wb_req = '0;
    endtask

    function automatic logic [31:0] model_read(input logic [31:0] adr);
        if (adr[31:24] != `AV_REG_REGION) begin
            return 32'h0;
        end
        case (adr[23:0])
            `AV_REG_COLOR:  return {20'h0, model_color};
            `AV_REG_LEFT:   return {16'h0, model_left};
            `AV_REG_RIGHT:  return {16'h0, model_right};
            `AV_REG_FRAMES: return {16'h0, vs_count[15:0]};
            default:        return 32'h0;
        endcase
    endfunction

    task automatic reg_write(input logic [31:0] adr, input logic [31:0] dat);
        av_pkg::wb_rsp_t rsp;
        int              lat;
        bus_access(1'b1, adr, dat, rsp, lat);
        // only the bits each register holds, frame count read only
        if (adr[31:24] == `AV_REG_REGION) begin
            case (adr[23:0])
                `AV_REG_COLOR: model_color = av_pkg::rgb444_t'(dat[11:0]);
                `AV_REG_LEFT:  model_left  = dat[15:0];
                `AV_REG_RIGHT: model_right = dat[15:0];
                default: begin
                end
            endcase
        end
    endtask

    task automatic reg_read_check(input string name, input logic [31:0] adr);
        av_pkg::wb_rsp_t rsp;
        av_pkg::wb_rsp_t want;
        int              lat;
        bus_access(1'b0, adr, 32'h0, rsp, lat);
        want.ack = 1'b1;
        want.dat = model_read(adr);
        check_rsp(name, want, rsp);
    endtask

    // mapped, unmapped in the window, and outside the window
    function automatic logic [31:0] pick_addr(input logic [2:0] sel);
        case (sel)
            3'd0:    return {`AV_REG_REGION, `AV_REG_COLOR};
            3'd1:    return {`AV_REG_REGION, `AV_REG_LEFT};
            3'd2:    return {`AV_REG_REGION, `AV_REG_RIGHT};
            3'd3:    return {`AV_REG_REGION, `AV_REG_FRAMES};
            3'd4:    return {`AV_REG_REGION, 24'h00_0010};
            3'd5:    return {`AV_REG_REGION, 24'h00_0040};
            3'd6:    return 32'h7700_0004;
            default: return 32'h1000_0000;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // edge waits, sampled on falling master clock edges
    ////////////////////////////////////////////////////////////

    task automatic wait_lrck_fall();
        logic prev;
        prev = i2s.lrck;
        @(negedge audgen_mclk);
        while (!(prev && !i2s.lrck)) begin
            prev = i2s.lrck;
            @(negedge audgen_mclk);
        end
    endtask

    // also returns how many master clocks the wait took
    task automatic wait_sclk_rise(output int cycles);
        logic prev;
        prev = i2s.sclk;
        cycles = 0;
        @(negedge audgen_mclk);
        cycles++;
        while (!(!prev && i2s.sclk)) begin
            prev = i2s.sclk;
            @(negedge audgen_mclk);
            cycles++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic register_test();
        int rnd;
        int k;
        for (k = 0; k < 32; k++) begin
            rnd = $random(seed);
            if (rnd[3]) begin
                reg_write(pick_addr(rnd[2:0]), $random(seed));
            end else begin
                reg_read_check("random read", pick_addr(rnd[2:0]));
            end
        end
        // unmapped and frame count writes must have left no trace
        for (k = 0; k < 8; k++) begin
            reg_read_check("register readback", pick_addr(k[2:0]));
        end
    endtask

    task automatic audio_test();
        logic [63:0] dac_bits;
        int          rnd;
        int          k;
        int          period;
        wait_lrck_fall();
        rnd = $random(seed);
        reg_write({`AV_REG_REGION, `AV_REG_LEFT}, {16'h0, rnd[15:0]});
        reg_write({`AV_REG_REGION, `AV_REG_RIGHT}, {16'h0, rnd[31:16]});
        // both samples latch here, left slot first
        wait_lrck_fall();
        dac_bits = '0;
        for (k = 0; k < 2 * `AV_SLOT_BITS; k++) begin
            wait_sclk_rise(period);
            // first rise is half a bit clock after the lrck edge
            expect_count("sclk period", (k == 0) ? `AV_SCLK_DIV / 2 : `AV_SCLK_DIV,
                         period);
            // low for the left slot, high for the right
            expect_count("lrck level", (k >= `AV_SLOT_BITS) ? 1 : 0, int'(i2s.lrck));
            dac_bits = {dac_bits[62:0], i2s.dac};
        end
        check_i2s_sample("left sample", model_left, dac_bits[63:48]);
        check_i2s_sample("left slot tail", 16'h0, dac_bits[47:32]);
        check_i2s_sample("right sample", model_right, dac_bits[31:16]);
        check_i2s_sample("right slot tail", 16'h0, dac_bits[15:0]);
    endtask

    task automatic raster_test();
        av_pkg::video_out_t want;
        int                 n;
        int                 x;
        int                 y;
        int                 last_hs;
        int                 de_run;
        int                 de_lines;
        logic               de_prev;
        // still in the top blanking of the first frame
        reg_write({`AV_REG_REGION, `AV_REG_COLOR}, $random(seed));
        while (!video.vs) begin
            @(negedge audgen_mclk);
        end
        last_hs  = -1;
        de_run   = 0;
        de_lines = 0;
        de_prev  = 1'b0;
        // one whole frame, up to and including the next vs
        for (n = 0; n <= FRAME_CYCLES; n++) begin
            x = n % `AV_H_TOTAL;
            y = (n / `AV_H_TOTAL) % `AV_V_TOTAL;
            want.vs  = (x == 0) && (y == 0);
            want.hs  = (x == `AV_HS_X);
            want.de  = (x >= `AV_H_BPORCH) && (x < `AV_H_BPORCH + `AV_H_ACTIVE) &&
                       (y >= `AV_V_BPORCH) && (y < `AV_V_BPORCH + `AV_V_ACTIVE);
            want.rgb = want.de ? {model_color.r, 4'h0, model_color.g, 4'h0,
                                  model_color.b, 4'h0} : 24'h0;
            check_video("raster", want, video);
            if (video.hs) begin
                if (last_hs >= 0) begin
                    expect_count("hs spacing", `AV_H_TOTAL, n - last_hs);
                end
                last_hs = n;
            end
            if (video.de && !de_prev) begin
                expect_count("de start after hs", `AV_H_BPORCH - `AV_HS_X, n - last_hs);
            end
            if (video.de) begin
                de_run++;
            end else if (de_prev) begin
                expect_count("de cycles per line", `AV_H_ACTIVE, de_run);
                de_run = 0;
                de_lines++;
            end
            de_prev = video.de;
            if (n < FRAME_CYCLES) begin
                @(negedge audgen_mclk);
            end
        end
        expect_count("lines with de", `AV_V_ACTIVE, de_lines);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        av_pkg::wb_rsp_t rsp;
        av_pkg::wb_rsp_t want;
        int              lat;
        seed    = 44983;
        reset_n = 1'b0;
        wb_req  = '0;
        repeat (16) @(negedge audgen_mclk);
        check_rsp("reset bus response", '0, wb_rsp);
        check_video("reset video", '0, video);
        check_i2s_sample("reset i2s", 16'h0, {13'h0, i2s});
        reset_n = 1'b1;
        // first access straight out of reset
        bus_access(1'b0, {`AV_REG_REGION, `AV_REG_COLOR}, 32'h0, rsp, lat);
        expect_count("first ack latency", 1, lat);
        want.ack = 1'b1;
        want.dat = 32'h0;
        check_rsp("first read", want, rsp);
        register_test();
        audio_test();
        raster_test();
        // the last vs is counted on the rising edge that ends it
        @(negedge audgen_mclk);
        expect_count("vs pulses seen", 3, vs_count);
        reg_read_check("frame count", {`AV_REG_REGION, `AV_REG_FRAMES});
        $display(">>> PASS");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge audgen_mclk);
        stop_run("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+source
source/av_pkg.sv
source/av_bus_regs.sv
source/video_timing_gen.sv
source/i2s_serializer.sv
source/av_signal_top.sv
verif/av_signal_assert.sv
verif/av_signal_tb.sv

// File: run.sh
#!/bin/sh
# build with verilator and run, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module av_signal_tb \
    -o av_signal_sim &&
./obj_dir/av_signal_sim ||
{ echo "simulation did not pass"; exit 1; }
